//--- source/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Cache geometry
`define ICACHE_WAYS     4
`define ICACHE_SETS     64
`define ICACHE_LINE_W   128

// Fetch address split
`define ICACHE_ADDR_W   64
`define ICACHE_TAG_W    54   // Bits 63..10
`define ICACHE_INDEX_W  6    // Bits 9..4
`define ICACHE_WORD_W   2    // Bits 3..2
`define ICACHE_OFFSET_W 4    // Byte offset inside a line

// Refill port half width
`define ICACHE_HALF_W   (`ICACHE_LINE_W / 2)

`endif

//--- source/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

	// One bit per way
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

	// Fetch address, tag on top
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0]   tag;
		logic [`ICACHE_INDEX_W-1:0] index;
		logic [`ICACHE_WORD_W-1:0]  word;
		logic [1:0]                 byte_off; // Ignored by the cache
	} fetch_addr_t;

	// One cache line, seen by refill or by fetch
	typedef union packed {
		logic [1:0][`ICACHE_HALF_W-1:0] halves; // Index 0 is the low half
		logic [3:0][31:0]               words;
	} line_u;

endpackage

//--- source/icache_lookup_if.sv
`include "icache_consts.svh"

interface icache_lookup_if;
	import icache_pkg::*;

	logic [`ICACHE_INDEX_W-1:0] index;
	way_mask_t                  hit_way;    // Current cycle compare
	way_mask_t                  alloc_way;  // Way being refilled
	logic                       advance;    // Pipeline moves this edge
	way_mask_t                  result_way; // Zero selects the refill line

	modport tag_side (
		output index,
		output hit_way,
		output alloc_way,
		output advance,
		output result_way
	);

	modport data_side (
		input index,
		input hit_way,
		input alloc_way,
		input advance,
		input result_way
	);

endinterface

//--- source/icache_addr_decode.sv
`include "icache_consts.svh"

module icache_addr_decode (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`ICACHE_ADDR_W-1:0]  addr,
	input  logic                       out_ready,
	output icache_pkg::fetch_addr_t    fields,
	output logic [`ICACHE_WORD_W-1:0]  word_prev
);

	// Plain bit slicing through the struct
	assign fields = addr;

	// Word select of the request now in the data stage
	always_ff @(posedge clk) begin
		if (rst) begin
			word_prev <= '0;
		end else if (out_ready) begin
			word_prev <= fields.word;
		end
	end

endmodule

//--- source/icache_tag_lookup.sv
`include "icache_consts.svh"

module icache_tag_lookup (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::fetch_addr_t fields,
	input  logic                    valid,
	input  logic                    flush,
	input  logic                    out_ready,
	output logic                    mem_req,
	icache_lookup_if.tag_side       lookup
);
	import icache_pkg::*;

	logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0]  valid_bits [`ICACHE_WAYS];

	way_mask_t hit_way;
	way_mask_t victim;     // Rotating one-hot replacement pointer
	way_mask_t alloc_way;
	way_mask_t result_way;
	logic      miss;

	generate
		for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
			assign hit_way[w] = valid_bits[w][fields.index] &&
				(tag_mem[w][fields.index] == fields.tag);

			always_ff @(posedge clk) begin
				if (rst) begin
					valid_bits[w] <= '0;
				end else if (alloc_way[w]) begin
					valid_bits[w][fields.index] <= 1'b1;
				end
			end

			// Visible to the compare on the next cycle
			always_ff @(posedge clk) begin
				if (alloc_way[w]) begin
					tag_mem[w][fields.index] <= fields.tag;
				end
			end
		end
	endgenerate

	assign miss    = valid && (hit_way == '0);
	assign mem_req = miss;

	// Flush does not block the refill, only a stall does
	assign alloc_way = (miss && out_ready) ? victim : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_mask_t'(1);
		end else if (out_ready && !flush) begin
			victim <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
		end
	end

	// Hit way of the request moving to the data stage
	always_ff @(posedge clk) begin
		if (rst) begin
			result_way <= '0;
		end else if (out_ready) begin
			result_way <= flush ? '0 : hit_way;
		end
	end

	assign lookup.index      = fields.index;
	assign lookup.hit_way    = hit_way;
	assign lookup.alloc_way  = alloc_way;
	assign lookup.advance    = out_ready;
	assign lookup.result_way = result_way;

endmodule

//--- source/icache_data_array.sv
`include "icache_consts.svh"

module icache_data_array (
	input  logic                      clk,
	input  logic                      rst,
	icache_lookup_if.data_side        lookup,
	input  logic [`ICACHE_WORD_W-1:0] word_prev,
	input  logic [`ICACHE_HALF_W-1:0] mem_lo,
	input  logic [`ICACHE_HALF_W-1:0] mem_hi,
	input  logic                      valid,
	input  logic                      flush,
	output logic [31:0]               inst,
	output logic                      ready
);
	import icache_pkg::*;

	line_u refill_line;
	line_u bypass_line; // Refill line of the previous request
	line_u out_line;
	line_u rd_data [`ICACHE_WAYS];

	assign refill_line.halves = {mem_hi, mem_lo};

	generate
		for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
			logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_SETS];

			always_ff @(posedge clk) begin
				if (lookup.alloc_way[w]) begin
					line_mem[lookup.index] <= refill_line;
				end
			end

			// Only the hit way is read, others keep their last data
			always_ff @(posedge clk) begin
				if (lookup.advance && lookup.hit_way[w]) begin
					rd_data[w] <= line_mem[lookup.index];
				end
			end
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (lookup.advance) begin
			bypass_line <= refill_line;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
		end else if (lookup.advance) begin
			ready <= valid && !flush;
		end
	end

	always_comb begin
		out_line = bypass_line; // Miss path
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (lookup.result_way[w]) begin
				out_line = rd_data[w];
			end
		end
	end

	assign inst = out_line.words[word_prev];

endmodule

//--- source/icache_top.sv
`include "icache_consts.svh"

module icache_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`ICACHE_ADDR_W-1:0] addr,
	input  logic                      valid,
	input  logic                      flush,
	input  logic                      out_ready,
	input  logic [`ICACHE_HALF_W-1:0] mem_lo,
	input  logic [`ICACHE_HALF_W-1:0] mem_hi,
	output logic [31:0]               inst,
	output logic                      ready,
	output logic [`ICACHE_ADDR_W-1:0] mem_addr,
	output logic                      mem_req
);
	import icache_pkg::*;

	fetch_addr_t                fields;
	logic [`ICACHE_WORD_W-1:0]  word_prev;

	icache_lookup_if lookup ();

	// Line aligned refill address
	assign mem_addr = {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

	icache_addr_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.out_ready (out_ready),
		.fields    (fields),
		.word_prev (word_prev)
	);

	icache_tag_lookup u_tag (
		.clk       (clk),
		.rst       (rst),
		.fields    (fields),
		.valid     (valid),
		.flush     (flush),
		.out_ready (out_ready),
		.mem_req   (mem_req),
		.lookup    (lookup.tag_side)
	);

	icache_data_array u_data (
		.clk       (clk),
		.rst       (rst),
		.lookup    (lookup.data_side),
		.word_prev (word_prev),
		.mem_lo    (mem_lo),
		.mem_hi    (mem_hi),
		.valid     (valid),
		.flush     (flush),
		.inst      (inst),
		.ready     (ready)
	);

endmodule

//--- verif/icache_chk.sv
module icache_chk (
	input logic                  clk,
	input logic                  rst,
	input logic                  valid,
	input icache_pkg::way_mask_t hit_way,
	input icache_pkg::way_mask_t victim,
	input icache_pkg::way_mask_t alloc_way
);
	timeunit 1ns;
	timeprecision 1ps;

	// A tag may live in one way only
	hit_way_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(hit_way)
	) else $error("More than one way hit at the same index");

	victim_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot(victim)
	) else $error("Victim pointer is not one-hot");

	// Refill only for a valid request that missed
	alloc_only_on_miss: assert property (
		@(posedge clk) disable iff (rst)
		(alloc_way != '0) |-> (valid && (hit_way == '0))
	) else $error("Way allocated without a valid missing request");

endmodule

//--- verif/icache_tb.sv
`include "icache_consts.svh"

module icache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD      = 100;
	localparam int DRIVE_DELAY     = 10;
	localparam int CHECK_DELAY     = 30;
	localparam int RESET_CYCLES    = 5;
	localparam int DIRECTED_CYCLES = 60; // Upper bound of the directed phases
	localparam int RANDOM_CYCLES   = 400;
	localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

	logic                      clk;
	logic                      rst;
	logic [63:0]               addr;
	logic                      valid;
	logic                      flush;
	logic                      out_ready;
	logic [63:0]               mem_lo;
	logic [63:0]               mem_hi;
	logic [31:0]               inst;
	logic                      ready;
	logic [63:0]               mem_addr;
	logic                      mem_req;
	logic [`ICACHE_LINE_W-1:0] mem_data;

	// Reference model of the cache contents
	logic [`ICACHE_TAG_W-1:0]  model_tag  [`ICACHE_WAYS][`ICACHE_SETS];
	logic                      model_vld  [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_LINE_W-1:0] model_line [`ICACHE_WAYS][`ICACHE_SETS];
	logic [1:0]                model_victim;
	logic                      exp_ready;
	logic [31:0]               exp_inst;

	logic [31:0] lfsr;
	int          gen;       // Memory contents generation
	int          hit_count;
	int          miss_count;
	int          err_count;

	icache_top dut (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.valid     (valid),
		.flush     (flush),
		.out_ready (out_ready),
		.mem_lo    (mem_lo),
		.mem_hi    (mem_hi),
		.inst      (inst),
		.ready     (ready),
		.mem_addr  (mem_addr),
		.mem_req   (mem_req)
	);

	bind icache_tag_lookup icache_chk u_chk (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.hit_way   (hit_way),
		.victim    (victim),
		.alloc_way (alloc_way)
	);

	function automatic logic [31:0] mem_word(logic [63:0] base, int g, int k);
		logic [31:0] mix;
		mix = base[63:32] ^ base[31:0] ^ (32'(g) * 32'h9e37_79b9);
		return mix ^ {8'(k), 8'(g), 16'h5a00} ^ {base[9:4], 26'h0};
	endfunction

	function automatic logic [`ICACHE_LINE_W-1:0] mem_line(logic [63:0] base, int g);
		return {mem_word(base, g, 3), mem_word(base, g, 2),
			mem_word(base, g, 1), mem_word(base, g, 0)};
	endfunction

	function automatic logic [63:0] line_base(logic [63:0] a);
		return {a[63:4], 4'h0};
	endfunction

	// Backing memory answers in the same cycle
	assign mem_data = mem_line(mem_addr, gen);
	assign mem_lo   = mem_data[63:0];
	assign mem_hi   = mem_data[127:64];

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [63:0] make_addr(logic [2:0] t, logic [1:0] s, logic [1:0] w);
		logic [`ICACHE_TAG_W-1:0] tag;
		tag = {t, 3'b110, 42'h0, 3'b011, t};
		return {tag, s, 4'hb, w, 2'b00};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		err_count++;
		$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
		$display("Test FAILED");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic report_failure(input string what);
		err_count++;
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Test FAILED");
		$fatal(1, "Stopped on a failed check");
	endtask

	task automatic check_value(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		assert (act_val === exp_val) else report_mismatch(name, exp_val, act_val);
	endtask

	task automatic find_way(input logic [63:0] a, output logic found, output logic [1:0] way);
		found = 1'b0;
		way   = 2'd0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_vld[w][a[9:4]] && (model_tag[w][a[9:4]] == a[63:10])) begin
				found = 1'b1;
				way   = 2'(w);
			end
		end
	endtask

	// Entered just after the drive point and left at the next one
	task automatic run_cycle(input logic [63:0] a, input logic v, input logic f, input logic r);
		logic                      found;
		logic [1:0]                way;
		logic                      exp_req;
		logic [`ICACHE_LINE_W-1:0] line;
		logic [5:0]                idx;
		idx       = a[9:4];
		addr      = a;
		valid     = v;
		flush     = f;
		out_ready = r;
		#(CHECK_DELAY);
		find_way(a, found, way);
		exp_req = v && !found;
		check_value("ready", 64'(exp_ready), 64'(ready));
		if (exp_ready) begin
			check_value("inst", 64'(exp_inst), 64'(inst));
		end
		check_value("mem_req", 64'(exp_req), 64'(mem_req));
		if (exp_req) begin
			check_value("mem_addr", line_base(a), mem_addr);
		end
		if (r) begin
			exp_ready = v && !f;
			line      = found ? model_line[way][idx] : mem_line(line_base(a), gen);
			exp_inst  = line[{a[3:2], 5'b00000} +: 32];
			if (exp_req) begin
				miss_count++;
				model_vld[model_victim][idx]  = 1'b1;
				model_tag[model_victim][idx]  = a[63:10];
				model_line[model_victim][idx] = line;
			end else if (v) begin
				hit_count++;
			end
			if (!f) model_victim = model_victim + 2'd1; // Turns even when idle
		end
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic fetch(input logic [63:0] a);
		run_cycle(a, 1'b1, 1'b0, 1'b1);
	endtask

	task automatic idle_cycle();
		run_cycle(64'h0, 1'b0, 1'b0, 1'b1);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD * 2);
		$display("ERROR at %0t ns: watchdog expired before the tests finished", $time);
		$display("Test FAILED");
		$fatal(1, "Watchdog timeout");
	end

	initial begin
		logic [63:0] a0;
		logic [63:0] a1;
		logic [63:0] a2;
		logic [63:0] cur_a;
		logic        cur_v;
		logic        cur_f;
		logic        cur_r;
		logic        hold;
		logic [31:0] bits;
		logic [2:0]  t_sel;
		logic [1:0]  s_sel;
		logic [1:0]  w_sel;

		rst          = 1'b1;
		addr         = '0;
		valid        = 1'b0;
		flush        = 1'b0;
		out_ready    = 1'b0;
		gen          = 0;
		lfsr         = 32'd39;
		hit_count    = 0;
		miss_count   = 0;
		err_count    = 0;
		exp_ready    = 1'b0;
		exp_inst     = '0;
		model_victim = 2'd0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				model_vld[w][s]  = 1'b0;
				model_tag[w][s]  = '0;
				model_line[w][s] = '0;
			end
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;

		// Cold miss and a neighbour word of the fresh line
		a0 = make_addr(3'd0, 2'd0, 2'd1);
		fetch(a0);
		fetch(make_addr(3'd0, 2'd0, 2'd2));
		idle_cycle();

		// Stale generation must still come from the cache
		gen++;
		for (int w = 0; w < 4; w++) begin
			fetch(make_addr(3'd0, 2'd0, 2'(w)));
		end
		idle_cycle();

		// Five tags into one set
		gen++;
		for (int t = 1; t < 5; t++) begin
			fetch(make_addr(3'(t), 2'd0, 2'd3));
		end
		gen++;
		for (int t = 0; t < 5; t++) begin
			fetch(make_addr(3'(t), 2'd0, 2'(t)));
		end
		idle_cycle();

		// Miss under flush still fills its line
		a1 = make_addr(3'd5, 2'd2, 2'd0);
		run_cycle(a1, 1'b1, 1'b1, 1'b1);
		fetch(make_addr(3'd5, 2'd2, 2'd3));
		idle_cycle();

		// Back-pressure over a miss result and a hit result
		a1 = make_addr(3'd6, 2'd3, 2'd1);
		a2 = make_addr(3'd7, 2'd3, 2'd2);
		fetch(a1);
		repeat (3) run_cycle(a2, 1'b1, 1'b0, 1'b0);
		run_cycle(a2, 1'b1, 1'b0, 1'b1);
		fetch(a1);
		repeat (2) run_cycle(a1, 1'b1, 1'b0, 1'b0);
		run_cycle(a1, 1'b1, 1'b0, 1'b1);
		idle_cycle();

		// Hits and misses of the random phase only
		hit_count  = 0;
		miss_count = 0;
		hold  = 1'b0;
		cur_a = '0;
		cur_v = 1'b0;
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			if (n % 100 == 50) gen++;
			take_bits(3, bits);
			t_sel = bits[2:0];
			take_bits(2, bits);
			s_sel = bits[1:0];
			take_bits(2, bits);
			w_sel = bits[1:0];
			if (!hold) begin
				cur_a = make_addr(t_sel, s_sel, w_sel); // Requester holds during a stall
				take_bits(3, bits);
				cur_v = (bits[2:0] != 3'd0);
			end
			take_bits(4, bits);
			cur_f = (bits[3:0] == 4'd0);
			take_bits(2, bits);
			cur_r = (bits[1:0] != 2'd0);
			run_cycle(cur_a, cur_v, cur_f, cur_r);
			hold = !cur_r;
		end
		idle_cycle();

		assert (hit_count > 0) else report_failure("no random request hit in the cache");
		assert (miss_count > 0) else report_failure("no random request missed in the cache");

		if (err_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- icache.f
+incdir+source
source/icache_pkg.sv
source/icache_lookup_if.sv
source/icache_addr_decode.sv
source/icache_tag_lookup.sv
source/icache_data_array.sv
source/icache_top.sv
verif/icache_chk.sv
verif/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the icache testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module icache_tb \
	-f icache.f -Mdir obj_dir -o icache_sim > "$LOG" 2>&1 &&
	./obj_dir/icache_sim >> "$LOG" 2>&1

grep -qx "Test OK" "$LOG" && echo "PASS" || {
	echo "FAIL, see $LOG"
	exit 1
}
